//--- src.f
hw/dataMemPkg.sv
hw/memBusIf.sv
hw/busDecoder.sv
hw/dataRam.sv
hw/ioRegisters.sv
hw/bcdSplitter.sv
hw/segEncoder.sv
hw/readMux.sv
hw/dataMemTop.sv
verification/dataMem_assert.sv
verification/dataMemTb.sv

//--- Bender.yml
package:
  name: data_mem

sources:
  # RTL in compile order.
  - files:
      - hw/dataMemPkg.sv
      - hw/memBusIf.sv
      - hw/busDecoder.sv
      - hw/dataRam.sv
      - hw/ioRegisters.sv
      - hw/bcdSplitter.sv
      - hw/segEncoder.sv
      - hw/readMux.sv
      - hw/dataMemTop.sv

  # Testbench and bound assertions.
  - target: simulation
    files:
      - verification/dataMem_assert.sv
      - verification/dataMemTb.sv

//--- verification/dataMemTb.sv
`timescale 1ns/100ps

module dataMemTb import dataMemPkg::*; ();

    localparam int RamWords = 256;
    localparam int ResetTimeout = 10;
    localparam logic [SwitchWidth-1:0] SwitchValue = 8'hC3;

    // Segment patterns in gfedcba order with digit 9 first.
    localparam logic [9:0][SegWidth-1:0] SegTable = {
        7'h6F, 7'h7F, 7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
    };

    logic clk;
    logic reset;
    logic readEnable;
    logic writeEnable;
    logic [AddrWidth-1:0] address;
    wordT writeData;
    logic [SwitchWidth-1:0] switch;
    logic [LedWidth-1:0] led;
    logic [TubeWidth-1:0] tube;
    wordT readData;

    // Stimulus table with one entry per clock cycle.
    logic rdQ [$];
    logic wrQ [$];
    logic [AddrWidth-1:0] addrQ [$];
    wordT dataQ [$];
    wordT expQ [$];
    wordT ledQ [$];
    wordT tubeQ [$];

    wordT ramModel [RamWords];
    logic [LedWidth-1:0] ledModel;
    logic [TubeWidth-1:0] tubeModel;
    integer seed = 9;

    dataMemTop uut (
        .clk        (clk),
        .reset      (reset),
        .readEnable (readEnable),
        .writeEnable(writeEnable),
        .address    (address),
        .writeData  (writeData),
        .switch     (switch),
        .led        (led),
        .tube       (tube),
        .readData   (readData)
    );

    always #10 clk = ~clk;

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

    task automatic compareValue(input string name, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic checkAssertions();
        if (uut.checks.failCount != 0) begin
            $display("A bound assertion failed");
            $display("Test failed");
            $fatal(1, "Assertion failure");
        end
    endtask

    function automatic wordT tableEntry(input int n);
        int hundreds;
        int tens;
        int ones;
        hundreds = n / 100;
        tens = (n / 10) % 10;
        ones = n % 10;
        return {11'b0, SegTable[hundreds], SegTable[tens], SegTable[ones]};
    endfunction

    function automatic wordT readModel(input logic [AddrWidth-1:0] addr);
        if (addr < 4 * RamWords) return ramModel[addr[9:2]];
        if (addr >= TableBase && addr < TableBase + 1024) return tableEntry(addr[9:2]);
        if (addr == SwitchAddr) return 32'(SwitchValue);
        if (addr == LedAddr) return 32'(ledModel);
        if (addr == TubeAddr) return 32'(tubeModel);
        return '0;                                                  // Unmapped.
    endfunction

    task automatic writeModel(input logic [AddrWidth-1:0] addr, input wordT data);
        if (addr < 4 * RamWords) begin
            ramModel[addr[9:2]] = data;
        end else if (addr == LedAddr) begin
            ledModel = data[LedWidth-1:0];
        end else if (addr == TubeAddr) begin
            tubeModel = data[TubeWidth-1:0];
        end
    endtask

    // Expected read value sees the model before this entry's write.
    task automatic addEntry(input logic rd, input logic wr, input logic [AddrWidth-1:0] addr,
                            input wordT data);
        rdQ.push_back(rd);
        wrQ.push_back(wr);
        addrQ.push_back(addr);
        dataQ.push_back(data);
        expQ.push_back(rd ? readModel(addr) : '0);
        if (wr) begin
            writeModel(addr, data);
        end
        ledQ.push_back(32'(ledModel));
        tubeQ.push_back(32'(tubeModel));
    endtask

    task automatic buildTable();
        logic [AddrWidth-1:0] ramAddr [16];
        int fixedIdx [6] = '{0, 7, 10, 99, 128, 255};
        int n;
        addEntry(1'b1, 1'b0, 32'd0, '0);                            // RAM cleared by reset.
        addEntry(1'b1, 1'b0, 32'd4, '0);
        addEntry(1'b1, 1'b0, 32'd1020, '0);
        foreach (ramAddr[i]) begin
            ramAddr[i] = 32'(({$random(seed)} % RamWords) * 4);
        end
        for (int i = 0; i < 8; i++) begin
            addEntry(1'b0, 1'b1, ramAddr[i], $random(seed));
            addEntry(1'b1, 1'b0, ramAddr[i], '0);
        end
        for (int i = 8; i < 16; i++) begin
            addEntry(1'b0, 1'b1, ramAddr[i], $random(seed));    // Back-to-back writes.
        end
        for (int i = 8; i < 16; i++) begin
            addEntry(1'b1, 1'b0, ramAddr[i], '0);               // Pipelined reads.
        end
        addEntry(1'b1, 1'b1, ramAddr[0], $random(seed));        // Old word comes back.
        addEntry(1'b1, 1'b0, ramAddr[0], '0);
        foreach (fixedIdx[i]) begin
            addEntry(1'b1, 1'b0, TableBase + 4 * fixedIdx[i], '0);
        end
        for (int i = 0; i < 20; i++) begin
            n = {$random(seed)} % 256;
            addEntry(1'b1, 1'b0, TableBase + 4 * n, '0);
        end
        addEntry(1'b0, 1'b1, TableBase + ramAddr[0], $random(seed));
        addEntry(1'b1, 1'b0, TableBase + ramAddr[0], '0);
        addEntry(1'b1, 1'b0, ramAddr[0], '0);
        addEntry(1'b0, 1'b1, LedAddr, 32'hFFFF_FFA5);
        addEntry(1'b0, 1'b1, TubeAddr, $random(seed));
        addEntry(1'b1, 1'b0, LedAddr, '0);
        addEntry(1'b1, 1'b0, TubeAddr, '0);
        addEntry(1'b1, 1'b0, SwitchAddr, '0);
        addEntry(1'b0, 1'b1, SwitchAddr, $random(seed));        // Switch port is read-only.
        addEntry(1'b1, 1'b0, SwitchAddr, '0);
        addEntry(1'b0, 1'b0, ramAddr[1], $random(seed));
        addEntry(1'b1, 1'b0, 32'h4000_0000, '0);
        addEntry(1'b1, 1'b0, 32'h4000_0018, '0);
        addEntry(1'b1, 1'b0, 32'h0000_0800, '0);
        addEntry(1'b1, 1'b0, 32'h8000_0000, '0);
        addEntry(1'b0, 1'b1, 32'h4000_0008, $random(seed));
        addEntry(1'b0, 1'b1, 32'h0000_0800, $random(seed));
        for (int i = 0; i < RamWords; i++) begin
            addEntry(1'b1, 1'b0, 32'(4 * i), '0);
        end
        addEntry(1'b1, 1'b0, LedAddr, '0);
        addEntry(1'b1, 1'b0, TubeAddr, '0);
    endtask

    task automatic driveEntry(input int i);
        readEnable = rdQ[i];
        writeEnable = wrQ[i];
        address = addrQ[i];
        writeData = dataQ[i];
    endtask

    task automatic checkEntry(input int i);
        compareValue("readData", readData, expQ[i]);
        compareValue("led", 32'(led), ledQ[i]);
        compareValue("tube", 32'(tube), tubeQ[i]);
    endtask

    initial begin
        int cycles;
        readEnable = 1'b0;
        writeEnable = 1'b0;
        address = '0;
        writeData = '0;
        switch = SwitchValue;
        ledModel = '0;
        tubeModel = '0;
        foreach (ramModel[i]) begin
            ramModel[i] = '0;
        end
        buildTable();
        cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > ResetTimeout) begin
                $display("Reset was not released within %0d cycles", ResetTimeout);
                $display("Test failed");
                $fatal(1, "Reset timeout");
            end
        end
        #1;
        compareValue("led", 32'(led), '0);
        compareValue("tube", 32'(tube), '0);
        compareValue("readData", readData, '0);
        checkAssertions();
        // Each result is checked one cycle after its entry is driven.
        for (int i = 0; i < rdQ.size(); i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                checkEntry(i - 1);
            end
            checkAssertions();
            driveEntry(i);
        end
        @(posedge clk);
        #1;
        checkEntry(rdQ.size() - 1);
        checkAssertions();
        readEnable = 1'b0;
        writeEnable = 1'b0;
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- verification/dataMem_assert.sv
`timescale 1ns/100ps

module dataMemAssert import dataMemPkg::*; (
    input logic clk,
    input logic reset,
    input logic readEnable,
    input logic writeEnable,
    input logic [LedWidth-1:0] led,
    input logic [TubeWidth-1:0] tube,
    input wordT readData
);

    int failCount = 0;                                              // Number of failed assertions.

    idleClearsRead: assert property (
        @(posedge clk) disable iff (reset) !readEnable |=> readData == '0
    ) else begin
        failCount++;
        $error("readData not zero after a cycle with readEnable low");
    end

    // Registers only move on a write strobe.
    ledHolds: assert property (
        @(posedge clk) disable iff (reset) !writeEnable |=> $stable(led)
    ) else begin
        failCount++;
        $error("led changed without a write");
    end

    tubeHolds: assert property (
        @(posedge clk) disable iff (reset) !writeEnable |=> $stable(tube)
    ) else begin
        failCount++;
        $error("tube changed without a write");
    end

    readZeroInReset: assert property (
        @(posedge clk) reset |-> readData == '0
    ) else begin
        failCount++;
        $error("readData not zero during reset");
    end

endmodule

bind dataMemTop dataMemAssert checks (
    .clk        (clk),
    .reset      (reset),
    .readEnable (readEnable),
    .writeEnable(writeEnable),
    .led        (led),
    .tube       (tube),
    .readData   (readData)
);

//--- hw/dataMemTop.sv
`timescale 1ns/100ps

module dataMemTop import dataMemPkg::*; #(
    parameter int RamAddrBits = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic readEnable,
    input  logic writeEnable,
    input  logic [AddrWidth-1:0] address,
    input  wordT writeData,
    input  logic [SwitchWidth-1:0] switch,
    output logic [LedWidth-1:0] led,
    output logic [TubeWidth-1:0] tube,
    output wordT readData
);

    wordT ramData;
    wordT ioData;
    logic [DigitCount-1:0][DigitWidth-1:0] digits;
    logic [DigitCount-1:0][SegWidth-1:0] patterns;

    memBusIf #(.RamAddrBits(RamAddrBits)) bus ();

    busDecoder #(.RamAddrBits(RamAddrBits)) decoder (
        .readEnable (readEnable),
        .writeEnable(writeEnable),
        .address    (address),
        .writeData  (writeData),
        .bus        (bus.decoder)
    );

    dataRam #(.RamAddrBits(RamAddrBits)) ram (
        .clk    (clk),
        .reset  (reset),
        .bus    (bus.target),
        .ramData(ramData)
    );

    ioRegisters io (
        .clk   (clk),
        .reset (reset),
        .bus   (bus.target),
        .switch(switch),
        .led   (led),
        .tube  (tube),
        .ioData(ioData)
    );

    bcdSplitter splitter (
        .bus   (bus.target),
        .digits(digits)
    );

    // One encoder per decimal digit.
    for (genvar d = 0; d < DigitCount; d++) begin : genDigit
        segEncoder encoder (
            .digit  (digits[d]),
            .pattern(patterns[d])
        );
    end

    readMux mux (
        .clk     (clk),
        .reset   (reset),
        .bus     (bus.target),
        .ramData (ramData),
        .ioData  (ioData),
        .patterns(patterns),
        .readData(readData)
    );

endmodule

//--- hw/readMux.sv
`timescale 1ns/100ps

module readMux import dataMemPkg::*; (
    input  logic clk,
    input  logic reset,
    memBusIf.target bus,
    input  wordT ramData,
    input  wordT ioData,
    input  logic [DigitCount-1:0][SegWidth-1:0] patterns,
    output wordT readData
);

    wordT tableWord;
    wordT nextData;

    // Hundreds land in the top pattern field and upper bits stay zero.
    assign tableWord = DataWidth'(patterns);

    always_comb begin
        if (!bus.readEnable) begin
            nextData = '0;
        end else begin
            case (bus.region)
                RegRam: nextData = ramData;
                RegSegTable: nextData = tableWord;
                RegSwitch, RegLed, RegTube: nextData = ioData;
                default: nextData = '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readData <= '0;
        end else begin
            readData <= nextData;                                   // One cycle for every region.
        end
    end

endmodule

//--- hw/segEncoder.sv
`timescale 1ns/100ps

module segEncoder import dataMemPkg::*; (
    input  logic [DigitWidth-1:0] digit,
    output logic [SegWidth-1:0] pattern
);

    // Active-high segments, bit order gfedcba.
    always_comb begin
        case (digit)
            4'd0: pattern = 7'h3F;
            4'd1: pattern = 7'h06;
            4'd2: pattern = 7'h5B;
            4'd3: pattern = 7'h4F;
            4'd4: pattern = 7'h66;
            4'd5: pattern = 7'h6D;
            4'd6: pattern = 7'h7D;
            4'd7: pattern = 7'h07;
            4'd8: pattern = 7'h7F;
            4'd9: pattern = 7'h6F;
            default: pattern = '0;                                  // Not a decimal digit.
        endcase
    end

endmodule

//--- hw/bcdSplitter.sv
`timescale 1ns/100ps

module bcdSplitter import dataMemPkg::*; (
    memBusIf.target bus,
    output logic [DigitCount-1:0][DigitWidth-1:0] digits
);

    localparam int BcdWidth = DigitCount * DigitWidth;

    // BCD digits sit above the binary part and fill as it shifts in.
    always_comb begin
        logic [BcdWidth+IndexWidth-1:0] work;
        logic [DigitWidth-1:0] nibble;

        work = '0;
        work[IndexWidth-1:0] = bus.wordIndex;
        for (int s = 0; s < IndexWidth; s++) begin
            for (int d = 0; d < DigitCount; d++) begin
                nibble = work[IndexWidth + d*DigitWidth +: DigitWidth];
                if (nibble > 4'd4) begin
                    work[IndexWidth + d*DigitWidth +: DigitWidth] = nibble + 4'd3;
                end
            end
            work = work << 1;
        end
        digits = work[IndexWidth +: BcdWidth];                      // Ones in digits[0].
    end

endmodule

//--- hw/ioRegisters.sv
`timescale 1ns/100ps

module ioRegisters import dataMemPkg::*; (
    input  logic clk,
    input  logic reset,
    memBusIf.target bus,
    input  logic [SwitchWidth-1:0] switch,
    output logic [LedWidth-1:0] led,
    output logic [TubeWidth-1:0] tube,
    output wordT ioData
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            led <= '0;
            tube <= '0;
        end else if (bus.writeEnable) begin
            case (bus.region)
                RegLed: led <= bus.writeData[LedWidth-1:0];
                RegTube: tube <= bus.writeData[TubeWidth-1:0];
                default: ;                                          // Switch port is read-only.
            endcase
        end
    end

    always_comb begin
        ioData = '0;
        case (bus.region)
            RegSwitch: ioData[SwitchWidth-1:0] = switch;
            RegLed: ioData[LedWidth-1:0] = led;
            RegTube: ioData[TubeWidth-1:0] = tube;
            default: ;
        endcase
    end

endmodule

//--- hw/dataRam.sv
`timescale 1ns/100ps

module dataRam import dataMemPkg::*; #(
    parameter int RamAddrBits = 8
) (
    input  logic clk,
    input  logic reset,
    memBusIf.target bus,
    output wordT ramData
);

    localparam int RamWords = 2 ** RamAddrBits;

    wordT mem [RamWords];

    logic writeHit;

    assign writeHit = bus.writeEnable && (bus.region == RegRam);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < RamWords; i++) begin
                mem[i] <= '0;                                       // Whole array cleared.
            end
        end else if (writeHit) begin
            mem[bus.ramIndex] <= bus.writeData;
        end
    end

    // The mux registers the old word on a same-cycle write.
    assign ramData = mem[bus.ramIndex];

endmodule

//--- hw/busDecoder.sv
`timescale 1ns/100ps

module busDecoder import dataMemPkg::*; #(
    parameter int RamAddrBits = 8
) (
    input  logic readEnable,
    input  logic writeEnable,
    input  logic [AddrWidth-1:0] address,
    input  wordT writeData,
    memBusIf.decoder bus
);

    localparam logic [AddrWidth-1:0] RamBytes = AddrWidth'(4 * (2 ** RamAddrBits));

    logic inRam;
    logic inTable;

    assign inRam = address < RamBytes;
    assign inTable = (address >= TableBase) && (address < TableBase + TableBytes);

    always_comb begin
        if (inRam) begin
            bus.region = RegRam;
        end else if (inTable) begin
            bus.region = RegSegTable;
        end else if (address == SwitchAddr) begin
            bus.region = RegSwitch;
        end else if (address == LedAddr) begin
            bus.region = RegLed;
        end else if (address == TubeAddr) begin
            bus.region = RegTube;
        end else begin
            bus.region = RegNone;                                   // Reads zero and drops writes.
        end
    end

    // Byte offset is dropped for both RAM and table.
    assign bus.wordIndex = address[IndexWidth+1:2];

    assign bus.readEnable = readEnable;
    assign bus.writeEnable = writeEnable;
    assign bus.writeData = writeData;

endmodule

//--- hw/memBusIf.sv
`timescale 1ns/100ps

interface memBusIf import dataMemPkg::*; #(
    parameter int RamAddrBits = 8
);

    logic readEnable;
    logic writeEnable;
    RegionE region;
    logic [IndexWidth-1:0] wordIndex;
    wordT writeData;

    // RAM word address, a slice of the shared index.
    logic [RamAddrBits-1:0] ramIndex;

    assign ramIndex = wordIndex[RamAddrBits-1:0];

    modport decoder (
        output readEnable,
        output writeEnable,
        output region,
        output wordIndex,
        output writeData
    );

    modport target (
        input readEnable,
        input writeEnable,
        input region,
        input wordIndex,
        input ramIndex,
        input writeData
    );

endinterface

//--- hw/dataMemPkg.sv
package dataMemPkg;

    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;

    typedef logic [DataWidth-1:0] wordT;

    // Regions the decoder can select.
    typedef enum logic [2:0] {
        RegRam,
        RegSegTable,
        RegSwitch,
        RegLed,
        RegTube,
        RegNone
    } RegionE;

    // Seven-segment table geometry.
    localparam int TableWords = 256;
    localparam int IndexWidth = $clog2(TableWords);                 // Word or table index bits.
    localparam logic [AddrWidth-1:0] TableBase = 32'd1024;
    localparam logic [AddrWidth-1:0] TableBytes = 32'(4 * TableWords);

    // Memory-mapped I/O addresses.
    localparam logic [AddrWidth-1:0] LedAddr = 32'h4000_000C;
    localparam logic [AddrWidth-1:0] SwitchAddr = 32'h4000_0010;
    localparam logic [AddrWidth-1:0] TubeAddr = 32'h4000_0014;

    // Port and field widths.
    localparam int SegWidth = 7;
    localparam int TubeWidth = 18;
    localparam int LedWidth = 8;
    localparam int SwitchWidth = 8;
    localparam int DigitWidth = 4;
    localparam int DigitCount = 3;                                  // Hundreds, tens, ones.

endpackage
